/* design/muldiv_op_pkg.sv */
package muldiv_op_pkg;

  // funct3 encodings of the RV32M group
  typedef enum logic [2:0] {
    OP_MUL    = 3'b000,
    OP_MULH   = 3'b001,
    OP_MULHSU = 3'b010,
    OP_MULHU  = 3'b011,
    OP_DIV    = 3'b100,
    OP_DIVU   = 3'b101,
    OP_REM    = 3'b110,
    OP_REMU   = 3'b111
  } muldiv_op_e;

  function automatic logic op_is_div(muldiv_op_e op);
    return op[2]; // upper four codes divide
  endfunction

  function automatic logic op_a_signed(muldiv_op_e op);
    return op inside {OP_MULH, OP_MULHSU, OP_DIV, OP_REM};
  endfunction

  function automatic logic op_b_signed(muldiv_op_e op);
    return op inside {OP_MULH, OP_DIV, OP_REM};
  endfunction

  // upper product word or remainder
  function automatic logic op_wants_high(muldiv_op_e op);
    return op inside {OP_MULH, OP_MULHSU, OP_MULHU, OP_REM, OP_REMU};
  endfunction

endpackage

/* design/muldiv_seq_pkg.sv */
package muldiv_seq_pkg;

  // execute sequencer
  typedef enum logic [1:0] {
    EXEC_IDLE = 2'b00,
    EXEC_RUN  = 2'b01,
    EXEC_DONE = 2'b10
  } exec_state_e;

  // which raw word goes out
  // lo is product low or quotient, hi is product high or remainder
  typedef enum logic {
    HALF_LO = 1'b0,
    HALF_HI = 1'b1
  } half_sel_e;

endpackage

/* design/muldiv_if.sv */
interface muldiv_if
  import muldiv_seq_pkg::*;
#(
  parameter int XLEN = 32
) ();

  logic            start;
  logic [XLEN-1:0] mag_a;
  logic [XLEN-1:0] mag_b;
  logic            is_div;
  half_sel_e       half;
  logic            neg_lo;
  logic            neg_hi;
  logic            div_zero;
  logic            div_ovf;
  logic [XLEN-1:0] a_raw; // untouched dividend

  logic [XLEN-1:0] raw_lo;
  logic [XLEN-1:0] raw_hi;
  logic            done;

  modport dec (
    output start, mag_a, mag_b, is_div, half, neg_lo, neg_hi,
           div_zero, div_ovf, a_raw
  );

  modport exe (
    input  start, mag_a, mag_b, is_div,
    output raw_lo, raw_hi, done
  );

  modport res (
    input half, neg_lo, neg_hi, div_zero, div_ovf, a_raw, is_div,
          raw_lo, raw_hi, done
  );

endinterface

/* design/muldiv_decode.sv */
module muldiv_decode
  import muldiv_op_pkg::*;
  import muldiv_seq_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            data_ready_i,
  input  muldiv_op_e      operation_i,
  input  logic [XLEN-1:0] operand1_i,
  input  logic [XLEN-1:0] operand2_i,
  input  logic            release_i,
  output logic            busy_o,
  muldiv_if.dec           bus
);

  localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

  logic            accept;
  logic            accepted_q; // second decode cycle
  muldiv_op_e      op_q;
  logic [XLEN-1:0] a_q;
  logic [XLEN-1:0] b_q;
  logic            a_neg;
  logic            b_neg;
  logic            div_op;

  assign accept = data_ready_i & ~busy_o;

  // effective signs only count for signed operands
  assign a_neg  = op_a_signed(op_q) & a_q[XLEN-1];
  assign b_neg  = op_b_signed(op_q) & b_q[XLEN-1];
  assign div_op = op_is_div(op_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_o     <= 1'b0;
      accepted_q <= 1'b0;
      bus.start  <= 1'b0;
    end else begin
      accepted_q <= accept;
      bus.start  <= accepted_q;
      if (accept) begin
        busy_o <= 1'b1;
      end else if (release_i) begin
        busy_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q <= operation_i;
      a_q  <= operand1_i;
      b_q  <= operand2_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accepted_q) begin
      bus.mag_a    <= a_neg ? -a_q : a_q;
      bus.mag_b    <= b_neg ? -b_q : b_q;
      bus.is_div   <= div_op;
      bus.half     <= op_wants_high(op_q) ? HALF_HI : HALF_LO;
      bus.neg_lo   <= a_neg ^ b_neg; // product or quotient sign
      bus.neg_hi   <= div_op ? a_neg : (a_neg ^ b_neg); // remainder follows dividend
      bus.div_zero <= div_op & (b_q == '0);
      bus.div_ovf  <= div_op & op_a_signed(op_q) & (a_q == MOST_NEG) & (b_q == '1);
      bus.a_raw    <= a_q;
    end
  end

endmodule

/* design/muldiv_execute.sv */
module muldiv_execute
  import muldiv_seq_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic  clk_i,
  input  logic  reset_i,
  muldiv_if.exe bus
);

  localparam int CNT_W = $clog2(XLEN);
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(XLEN - 1);

  exec_state_e       state;
  logic [CNT_W-1:0]  count;
  logic              div_mode;
  logic [XLEN-1:0]   opnd;       // multiplicand or divisor
  logic [2*XLEN-1:0] acc;        // {hi, lo}

  logic [XLEN:0]     mul_sum;
  logic [2*XLEN-1:0] mul_next;
  logic [XLEN:0]     rem_shift;
  logic [XLEN:0]     trial;
  logic [2*XLEN-1:0] div_next;

  // multiply step: add on lsb, then shift right with the carry
  always_comb begin
    mul_sum  = {1'b0, acc[2*XLEN-1:XLEN]} + (acc[0] ? {1'b0, opnd} : '0);
    mul_next = {mul_sum, acc[XLEN-1:1]};
  end

  // divide step: shift left, trial subtract, keep or restore
  always_comb begin
    rem_shift = acc[2*XLEN-1:XLEN-1];
    trial     = rem_shift - {1'b0, opnd};
    if (trial[XLEN]) begin
      div_next = {acc[2*XLEN-2:0], 1'b0}; // restore
    end else begin
      div_next = {trial[XLEN-1:0], acc[XLEN-2:0], 1'b1};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state <= EXEC_IDLE;
      count <= '0;
    end else begin
      case (state)
        EXEC_IDLE: begin
          count <= '0;
          if (bus.start) begin
            state <= EXEC_RUN;
          end
        end
        EXEC_RUN: begin
          count <= count + 1'b1;
          if (count == LAST_STEP) begin
            state <= EXEC_DONE;
          end
        end
        EXEC_DONE: state <= EXEC_IDLE;
        default:   state <= EXEC_IDLE;
      endcase
    end
  end

  // datapath, loaded on start
  always_ff @(posedge clk_i) begin
    if (state == EXEC_IDLE && bus.start) begin
      div_mode <= bus.is_div;
      if (bus.is_div) begin
        opnd <= bus.mag_b;
        acc  <= {{XLEN{1'b0}}, bus.mag_a}; // dividend shifts out of lo
      end else begin
        opnd <= bus.mag_a;
        acc  <= {{XLEN{1'b0}}, bus.mag_b}; // multiplier bits consumed from lsb
      end
    end else if (state == EXEC_RUN) begin
      acc <= div_mode ? div_next : mul_next;
    end
  end

  assign bus.raw_lo = acc[XLEN-1:0];
  assign bus.raw_hi = acc[2*XLEN-1:XLEN];
  assign bus.done   = (state == EXEC_DONE);

endmodule

/* design/muldiv_result.sv */
module muldiv_result
  import muldiv_seq_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic            clk_i,
  input  logic            reset_i,
  muldiv_if.res           bus,
  output logic [XLEN-1:0] result_o,
  output logic            data_ready_o,
  output logic            release_o
);

  logic            pick_hi;
  logic [XLEN-1:0] word;
  logic            neg;
  logic            carry_in;
  logic [XLEN-1:0] signed_word;
  logic [XLEN-1:0] final_word;

  assign pick_hi = (bus.half == HALF_HI);
  assign word    = pick_hi ? bus.raw_hi : bus.raw_lo;
  assign neg     = pick_hi ? bus.neg_hi : bus.neg_lo;

  // high product word negates as part of the 2*XLEN value
  assign carry_in    = (pick_hi && !bus.is_div) ? (bus.raw_lo == '0) : 1'b1;
  assign signed_word = neg ? (~word + XLEN'(carry_in)) : word;

  always_comb begin
    final_word = signed_word;
    if (bus.div_zero) begin
      final_word = pick_hi ? bus.a_raw : '1;
    end else if (bus.div_ovf) begin
      final_word = pick_hi ? '0 : bus.a_raw;
    end
  end

  // frees decode on the same edge data_ready_o rises
  assign release_o = bus.done;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_ready_o <= 1'b0;
    end else begin
      data_ready_o <= bus.done;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.done) begin
      result_o <= final_word; // held until next result
    end
  end

endmodule

/* design/muldiv_unit.sv */
module muldiv_unit
  import muldiv_op_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            data_ready_i,
  input  muldiv_op_e      operation_i,
  input  logic [XLEN-1:0] operand1_i,
  input  logic [XLEN-1:0] operand2_i,
  output logic [XLEN-1:0] result_o,
  output logic            data_ready_o,
  output logic            busy_o
);

  logic release_w; // result back to decode

  muldiv_if #(.XLEN(XLEN)) bus ();

  muldiv_decode #(
    .XLEN(XLEN)
  ) i_decode (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .data_ready_i(data_ready_i),
    .operation_i (operation_i),
    .operand1_i  (operand1_i),
    .operand2_i  (operand2_i),
    .release_i   (release_w),
    .busy_o      (busy_o),
    .bus         (bus.dec)
  );

  muldiv_execute #(
    .XLEN(XLEN)
  ) i_execute (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .bus    (bus.exe)
  );

  muldiv_result #(
    .XLEN(XLEN)
  ) i_result (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .bus         (bus.res),
    .result_o    (result_o),
    .data_ready_o(data_ready_o),
    .release_o   (release_w)
  );

endmodule

/* test/muldiv_unit_asserts.sv */
module muldiv_unit_asserts #(
  parameter int XLEN = 32
) (
  input logic clk_i,
  input logic reset_i,
  input logic req_i,   // data_ready_i
  input logic busy_i,
  input logic ready_i  // data_ready_o
);

  logic accept;

  assign accept = req_i & ~busy_i;

  ready_not_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    ready_i |-> !busy_i)
    else $error("data_ready_o high while busy_o is high");

  single_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    ready_i |=> !ready_i)
    else $error("data_ready_o high two cycles in a row");

  // same latency for every operation
  // ready rises XLEN+3 edges after acceptance and is sampled one edge later
  fixed_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    accept |-> ##(XLEN + 4) ready_i)
    else $error("data_ready_o missing %0d cycles after acceptance", XLEN + 3);

endmodule

bind muldiv_unit muldiv_unit_asserts #(
  .XLEN(XLEN)
) i_asserts (
  .clk_i  (clk_i),
  .reset_i(reset_i),
  .req_i  (data_ready_i),
  .busy_i (busy_o),
  .ready_i(data_ready_o)
);

/* test/muldiv_unit_tb.sv */
module muldiv_unit_tb
  import muldiv_op_pkg::*;
();

  localparam int XLEN    = 32;
  localparam int LATENCY = XLEN + 3;
  localparam int TIMEOUT = 4 * LATENCY;
  localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

  logic            clk_i;
  logic            reset_i;
  logic            data_ready_i;
  muldiv_op_e      operation_i;
  logic [XLEN-1:0] operand1_i;
  logic [XLEN-1:0] operand2_i;
  logic [XLEN-1:0] result_o;
  logic            data_ready_o;
  logic            busy_o;

  integer seed = 32'h7f948d50;
  int     tests;
  int     checks;
  int     errors;
  int     test_checks; // per test, folded into the totals by end_test
  int     test_errors;

  muldiv_unit #(
    .XLEN(XLEN)
  ) i_muldiv_unit (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .data_ready_i(data_ready_i),
    .operation_i (operation_i),
    .operand1_i  (operand1_i),
    .operand2_i  (operand2_i),
    .result_o    (result_o),
    .data_ready_o(data_ready_o),
    .busy_o      (busy_o)
  );

  always #50 clk_i = ~clk_i;

  // golden result from wide arithmetic
  function automatic logic [XLEN-1:0] model_result(muldiv_op_e op, logic [XLEN-1:0] a,
                                                   logic [XLEN-1:0] b);
    logic signed [2*XLEN-1:0] wa;
    logic signed [2*XLEN-1:0] wb;
    logic signed [2*XLEN-1:0] wide;
    wa = op_a_signed(op) ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
    wb = op_b_signed(op) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
    if (!op_is_div(op)) begin
      wide = wa * wb;
      return op_wants_high(op) ? wide[2*XLEN-1:XLEN] : wide[XLEN-1:0];
    end
    if (b == '0) begin
      return op_wants_high(op) ? a : '1; // divide by zero
    end
    if (op_a_signed(op) && a == MOST_NEG && b == '1) begin
      return op_wants_high(op) ? '0 : a; // signed overflow
    end
    wide = op_wants_high(op) ? (wa % wb) : (wa / wb); // truncating
    return wide[XLEN-1:0];
  endfunction

  // corner values show up often
  function automatic logic [XLEN-1:0] pick_operand();
    logic [31:0] kind;
    kind = {$random(seed)} % 8;
    case (kind)
      0:       return '0;
      1:       return '1;
      2:       return MOST_NEG;
      3:       return XLEN'({$random(seed)} % 16);
      default: return $random(seed);
    endcase
  endfunction

  task automatic check_value(input string what, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    test_checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_latency(input int cycles);
    test_checks++;
    assert (cycles == LATENCY) else begin
      $display("CHECK FAILED at %0t: latency %0d cycles, expected %0d", $time, cycles,
               LATENCY);
      test_errors++;
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy_o && n < TIMEOUT) begin
      @(posedge clk_i);
      #10;
      n++;
    end
    if (busy_o) begin
      $display("timeout: busy_o stayed high for %0d cycles at %0t", TIMEOUT, $time);
      test_errors++;
    end
  endtask

  // ends 10 units after the accepting edge
  task automatic issue(input muldiv_op_e op, input logic [XLEN-1:0] a,
                       input logic [XLEN-1:0] b);
    wait_idle();
    operation_i  = op;
    operand1_i   = a;
    operand2_i   = b;
    data_ready_i = 1'b1;
    @(posedge clk_i);
    #10;
    data_ready_i = 1'b0;
  endtask

  // start is the number of edges already passed since acceptance
  task automatic await_result(input int start, output logic [XLEN-1:0] got, output int cycles);
    cycles = start;
    got    = '0;
    do begin
      @(posedge clk_i);
      #10;
      cycles++;
    end while (!data_ready_o && cycles < TIMEOUT);
    if (data_ready_o) begin
      got = result_o;
    end else begin
      $display("timeout: no data_ready_o within %0d cycles at %0t", TIMEOUT, $time);
      test_errors++;
    end
  endtask

  task automatic run_request(input muldiv_op_e op, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b, input logic [XLEN-1:0] exp);
    logic [XLEN-1:0] got;
    int              cycles;
    issue(op, a, b);
    check_value("busy_o after acceptance", XLEN'(busy_o), XLEN'(1'b1));
    await_result(0, got, cycles);
    check_value($sformatf("%s %h, %h", op.name(), a, b), got, exp);
    check_latency(cycles);
  endtask

  task automatic end_test(input string name);
    $display("%-12s %0d checks, %0d errors", name, test_checks, test_errors);
    tests++;
    checks += test_checks;
    errors += test_errors;
    test_checks = 0;
    test_errors = 0;
  endtask

  initial begin
    muldiv_op_e      op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] got;
    int              cycles;
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    data_ready_i = 1'b0;
    operation_i  = OP_MUL;
    operand1_i   = '0;
    operand2_i   = '0;
    tests        = 0;
    checks       = 0;
    errors       = 0;
    test_checks  = 0;
    test_errors  = 0;
    repeat (2) @(posedge clk_i);
    #10;
    reset_i = 1'b0;

    check_value("busy_o after reset", XLEN'(busy_o), '0);
    check_value("data_ready_o after reset", XLEN'(data_ready_o), '0);
    end_test("reset");

    for (int i = 0; i < 200; i++) begin
      op = muldiv_op_e'(3'({$random(seed)} % 4));
      a  = pick_operand();
      b  = pick_operand();
      run_request(op, a, b, model_result(op, a, b));
    end
    end_test("multiply");

    for (int i = 0; i < 200; i++) begin
      op = muldiv_op_e'(3'(4 + {$random(seed)} % 4));
      a  = pick_operand();
      b  = pick_operand();
      run_request(op, a, b, model_result(op, a, b));
    end
    end_test("divide");

    a = $random(seed);
    run_request(OP_DIV, a, '0, '1);
    run_request(OP_DIVU, a, '0, '1);
    run_request(OP_REM, a, '0, a);
    run_request(OP_REMU, a, '0, a);
    run_request(OP_REM, '0, '0, '0);
    run_request(OP_DIV, MOST_NEG, '1, MOST_NEG);
    run_request(OP_REM, MOST_NEG, '1, '0);
    run_request(OP_DIVU, MOST_NEG, '1, '0); // no overflow when unsigned
    run_request(OP_REMU, MOST_NEG, '1, MOST_NEG);
    end_test("special");

    // request held high while busy must be ignored
    a = $random(seed);
    b = $random(seed);
    issue(OP_MULHU, a, b);
    for (int k = 0; k < XLEN; k++) begin
      operation_i  = OP_DIV;
      operand1_i   = $random(seed);
      operand2_i   = '0;
      data_ready_i = 1'b1;
      @(posedge clk_i);
      #10;
    end
    data_ready_i = 1'b0;
    await_result(XLEN, got, cycles);
    check_value("MULHU with request held while busy", got, model_result(OP_MULHU, a, b));
    check_latency(cycles);
    repeat (LATENCY + 2) begin
      @(posedge clk_i);
      #10;
      check_value("busy_o after ignored request", XLEN'(busy_o), '0);
      check_value("data_ready_o after ignored request", XLEN'(data_ready_o), '0);
    end
    // each issue lands on the ready cycle of the one before
    for (int i = 0; i < 16; i++) begin
      op = muldiv_op_e'(3'({$random(seed)} % 8));
      a  = pick_operand();
      b  = pick_operand();
      run_request(op, a, b, model_result(op, a, b));
    end
    end_test("handshake");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* muldiv_unit.f */
design/muldiv_op_pkg.sv
design/muldiv_seq_pkg.sv
design/muldiv_if.sv
design/muldiv_decode.sv
design/muldiv_execute.sv
design/muldiv_result.sv
design/muldiv_unit.sv
test/muldiv_unit_asserts.sv
test/muldiv_unit_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the muldiv_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f muldiv_unit.f \
  --top-module muldiv_unit_tb

output=$(./obj_dir/Vmuldiv_unit_tb)
echo "$output"

if echo "$output" | grep -qF "All tests passed!"; then
  exit 0
else
  exit 1
fi
